//--- Makefile
# Verilator flow for the array heap
TOP := heapMemoryTb
OBJ := obj_dir

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -Wall -f heapMemory.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f heapMemory.f \
		--top-module $(TOP) -Mdir $(OBJ)
	@out="$$(./$(OBJ)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation completed successfully"

clean:
	rm -rf $(OBJ)

//--- hdl/arrayAllocator.sv
/*
  Hands out array numbers, from the freed stack first, then from the
  high-water mark. allocate and free are one-cycle strobes that the caller
  raises only for commands that pass their checks, never both at once.
*/
`include "heapMemory_defs.svh"

module arrayAllocator (
  input  logic           clock,
  input  logic           reset,
  input  heapPkg::arrayT array,                 // Array named by the command
  input  logic           allocate,              // Take nextArray this cycle
  input  logic           free,                  // Return array this cycle
  output logic           neverAllocated,        // At or above high-water
  output logic           freed,                 // Below high-water but not live
  output heapPkg::arrayT nextArray,             // Array the next alloc gets
  output logic           outOfMemory            // Nothing left to hand out
);

  typedef logic [`HEAP_ARRAY_BITS:0] countT;    // Counts 0 to HEAP_ARRAYS

  countT                   highWater;           // Arrays ever handed out
  countT                   stackTop;            // Entries on the freed stack
  logic [`HEAP_ARRAYS-1:0] allocated;           // Live flag per array
  heapPkg::arrayT          freeStack [`HEAP_ARRAYS]; // Newest freed on top
  heapPkg::arrayT          topEntry;            // Slot of the newest entry
  logic                    stackEmpty;

  // ------------------------------
  // Status for the command's array
  // ------------------------------
  assign stackEmpty = stackTop == '0;
  assign topEntry   = stackTop[`HEAP_ARRAY_BITS-1:0] - 1'b1;

  // Reuse before growing
  assign nextArray = stackEmpty ? highWater[`HEAP_ARRAY_BITS-1:0]
                                : freeStack[topEntry];

  assign outOfMemory    = stackEmpty && (highWater == countT'(`HEAP_ARRAYS));
  assign neverAllocated = countT'(array) >= highWater;
  assign freed          = !neverAllocated && !allocated[array];

  // ------------------------------
  // State updates
  // ------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      highWater <= '0;
      stackTop  <= '0;
      allocated <= '0;
    end else begin
      if (allocate) begin
        allocated[nextArray] <= 1'b1;           // Mark live
        if (stackEmpty) begin
          highWater <= highWater + 1'b1;        // Fresh array
        end else begin
          stackTop <= stackTop - 1'b1;          // Pop the freed stack
        end
      end
      if (free) begin
        allocated[array] <= 1'b0;
        stackTop         <= stackTop + 1'b1;    // Push onto freed stack
      end
    end
  end

  // A live array is freed at most once, so the stack never overflows
  always_ff @(posedge clock) begin
    if (free) begin
      freeStack[stackTop[`HEAP_ARRAY_BITS-1:0]] <= array;
    end
  end

endmodule

//--- hdl/arraySizeTable.sv
/*
  One size per array. Status outputs describe the command's array and are
  combinational; updates land on the clock edge for updateArray. Increment
  and decrement are issued only after the full and empty checks.
*/
`include "heapMemory_defs.svh"

module arraySizeTable (
  input  logic            clock,
  input  logic            reset,
  input  heapPkg::arrayT  array,                // Array being checked
  input  heapPkg::indexT  index,                // Command index, also grow target
  input  heapPkg::arrayT  updateArray,          // Array whose size changes
  input  heapPkg::sizeOpT sizeOp,
  output heapPkg::sizeT   size,                 // Size of array
  output logic            inBounds,             // index below size
  output logic            full,
  output logic            empty
);

  heapPkg::sizeT sizes [`HEAP_ARRAYS];          // Current size of each array
  heapPkg::sizeT indexSize;                     // Index widened to a size
  heapPkg::sizeT current;                       // Size of updateArray

  // ------------------------------
  // Bounds and fill status
  // ------------------------------
  assign indexSize = heapPkg::sizeT'(index);
  assign size      = sizes[array];
  assign current   = sizes[updateArray];

  assign inBounds = indexSize < size;
  assign full     = size == heapPkg::sizeT'(`HEAP_LENGTH);
  assign empty    = size == '0;

  // ------------------------------
  // Size updates
  // ------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int a = 0; a < `HEAP_ARRAYS; a++) begin
        sizes[a] <= '0;                         // All arrays empty
      end
    end else begin
      case (sizeOp)
        heapPkg::sizeClear: begin
          sizes[updateArray] <= '0;             // Fresh or reused array
        end
        heapPkg::sizeGrowTo: begin
          if (indexSize >= current) begin       // Writes inside keep the size
            sizes[updateArray] <= indexSize + 1'b1;
          end
        end
        heapPkg::sizeIncrement: begin
          sizes[updateArray] <= current + 1'b1;
        end
        heapPkg::sizeDecrement: begin
          sizes[updateArray] <= current - 1'b1;
        end
        default: begin
          sizes[updateArray] <= current;        // sizeKeep
        end
      endcase
    end
  end

endmodule

//--- hdl/elementAlu.sv
/*
  New element value for each element-changing opcode. Add and subtract wrap.
  Shifts by HEAP_DATA_BITS or more give zero. Write and push pass the operand
  through so the store has one write data path.
*/
`include "heapMemory_defs.svh"

module elementAlu (
  input  heapPkg::opcodeT action,
  input  heapPkg::dataT   stored,               // Element before the change
  input  heapPkg::dataT   operand,              // Command data
  output heapPkg::dataT   updated               // Element after the change
);

  logic shiftOut;                               // Distance clears every bit

  assign shiftOut = operand >= heapPkg::dataT'(`HEAP_DATA_BITS);

  always_comb begin
    case (action)
      heapPkg::opWrite,
      heapPkg::opPush: begin
        updated = operand;                      // Plain store
      end
      heapPkg::opAdd,
      heapPkg::opAddAfter: begin
        updated = stored + operand;             // Wraps modulo 2**width
      end
      heapPkg::opSubtract,
      heapPkg::opSubAfter: begin
        updated = stored - operand;
      end
      heapPkg::opShiftLeft: begin
        updated = shiftOut ? '0 : stored << operand;
      end
      heapPkg::opShiftRight: begin
        updated = shiftOut ? '0 : stored >> operand;
      end
      heapPkg::opNotLogical: begin
        updated = heapPkg::dataT'(stored == '0);
      end
      heapPkg::opNot: updated = ~stored;
      heapPkg::opOr:  updated = stored | operand;
      heapPkg::opXor: updated = stored ^ operand;
      heapPkg::opAnd: updated = stored & operand;
      default: begin
        updated = stored;                       // Reads leave the element alone
      end
    endcase
  end

endmodule

//--- hdl/elementStore.sv
/*
  Element storage, HEAP_ARRAYS by HEAP_LENGTH. Read is asynchronous and
  write is on the clock edge at the same address, so a read-modify-write
  fits in one cycle. Contents are undefined until written.
*/
`include "heapMemory_defs.svh"

module elementStore (
  input  logic           clock,
  input  heapPkg::arrayT array,                 // Shared address, array part
  input  heapPkg::indexT index,                 // Shared address, element part
  input  logic           writeEnable,
  input  heapPkg::dataT  writeData,
  output heapPkg::dataT  readData               // Current content at address
);

  // ------------------------------
  // Storage
  // ------------------------------
  heapPkg::dataT memory [`HEAP_ARRAYS][`HEAP_LENGTH]; // Fixed block per array

  assign readData = memory[array][index];       // Old value during a write

  always_ff @(posedge clock) begin
    if (writeEnable) begin
      memory[array][index] <= writeData;
    end
  end

endmodule

//--- hdl/heapMemory.sv
/*
  Array heap top. One command per clock, result one cycle later. Side
  effects happen only for commands that pass every check; result.data holds
  when a command fails or returns nothing.
*/
module heapMemory (
  input  logic                 clock,
  input  logic                 reset,
  input  heapPkg::heapCommandT command,
  output heapPkg::heapResultT  result
);

  // Opcode classes
  logic isIdle;                                 // opNone or unused code
  logic isAlloc;
  logic isFree;
  logic isWrite;
  logic isRead;
  logic isSize;
  logic isPush;
  logic isPop;
  logic isElement;                              // Read-modify-write ops
  logic isAfter;                                // Returns the old value

  // Allocator and size table status
  logic            neverAllocated;
  logic            freed;
  logic            outOfMemory;
  heapPkg::arrayT  nextArray;
  heapPkg::sizeT   size;
  logic            inBounds;
  logic            full;
  logic            empty;

  // Side effects and result
  heapPkg::errorT  error;
  logic            succeeded;
  logic            hasValue;                    // Command returns data
  heapPkg::dataT   returnData;
  heapPkg::sizeOpT sizeOp;
  heapPkg::arrayT  updateArray;
  heapPkg::indexT  storeIndex;
  logic            storeWrite;
  heapPkg::dataT   stored;
  heapPkg::dataT   updated;

  // ------------------------------
  // Decode
  // ------------------------------
  always_comb begin
    isIdle    = 1'b0;
    isAlloc   = 1'b0;
    isFree    = 1'b0;
    isWrite   = 1'b0;
    isRead    = 1'b0;
    isSize    = 1'b0;
    isPush    = 1'b0;
    isPop     = 1'b0;
    isElement = 1'b0;
    isAfter   = 1'b0;
    case (command.action)
      heapPkg::opAlloc: isAlloc = 1'b1;
      heapPkg::opFree:  isFree  = 1'b1;
      heapPkg::opWrite: isWrite = 1'b1;
      heapPkg::opRead:  isRead  = 1'b1;
      heapPkg::opSize:  isSize  = 1'b1;
      heapPkg::opPush:  isPush  = 1'b1;
      heapPkg::opPop:   isPop   = 1'b1;
      heapPkg::opAddAfter,
      heapPkg::opSubAfter: begin
        isElement = 1'b1;
        isAfter   = 1'b1;
      end
      heapPkg::opAdd,
      heapPkg::opSubtract,
      heapPkg::opShiftLeft,
      heapPkg::opShiftRight,
      heapPkg::opNotLogical,
      heapPkg::opNot,
      heapPkg::opOr,
      heapPkg::opXor,
      heapPkg::opAnd: begin
        isElement = 1'b1;
      end
      default: isIdle = 1'b1;                   // opNone and spare codes
    endcase
  end

  // ------------------------------
  // Error priority
  // ------------------------------
  always_comb begin
    error = heapPkg::errNone;
    if (isAlloc) begin
      if (outOfMemory) begin
        error = heapPkg::errOutOfMemory;
      end
    end else if (!isIdle) begin                 // Everything else names an array
      if (neverAllocated) begin
        error = heapPkg::errNotAllocated;
      end else if (freed) begin
        error = heapPkg::errFreed;              // Also catches a double free
      end else if ((isRead || isElement) && !inBounds) begin
        error = heapPkg::errOutOfBounds;
      end else if (isPush && full) begin
        error = heapPkg::errFull;
      end else if (isPop && empty) begin
        error = heapPkg::errEmpty;
      end
    end
  end

  assign succeeded  = !isIdle && (error == heapPkg::errNone);
  assign storeWrite = succeeded && (isWrite || isPush || isElement);

  // ------------------------------
  // Size table control
  // ------------------------------
  assign updateArray = isAlloc ? nextArray : command.array;

  always_comb begin
    sizeOp = heapPkg::sizeKeep;
    if (succeeded) begin
      if (isAlloc) begin
        sizeOp = heapPkg::sizeClear;
      end else if (isWrite) begin
        sizeOp = heapPkg::sizeGrowTo;
      end else if (isPush) begin
        sizeOp = heapPkg::sizeIncrement;
      end else if (isPop) begin
        sizeOp = heapPkg::sizeDecrement;
      end
    end
  end

  // Push goes at the end, pop takes the last element
  always_comb begin
    if (isPush) begin
      storeIndex = heapPkg::indexT'(size);
    end else if (isPop) begin
      storeIndex = heapPkg::indexT'(size - 1'b1);
    end else begin
      storeIndex = command.index;
    end
  end

  // ------------------------------
  // Returned value
  // ------------------------------
  always_comb begin
    hasValue   = 1'b1;
    returnData = updated;                       // New element, or write data
    if (isAfter || isRead || isPop) begin
      returnData = stored;
    end else if (isSize) begin
      returnData = heapPkg::dataT'(size);
    end else if (isAlloc) begin
      returnData = heapPkg::dataT'(nextArray);
    end else if (isPush || isFree) begin
      hasValue = 1'b0;                          // Nothing to report
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      result.data  <= '0;
      result.error <= heapPkg::errNone;
    end else begin
      result.error <= error;
      if (succeeded && hasValue) begin
        result.data <= returnData;
      end
    end
  end

  // ------------------------------
  // Submodules
  // ------------------------------
  arrayAllocator i_allocator (
    .clock          (clock),
    .reset          (reset),
    .array          (command.array),
    .allocate       (isAlloc && succeeded),
    .free           (isFree && succeeded),
    .neverAllocated (neverAllocated),
    .freed          (freed),
    .nextArray      (nextArray),
    .outOfMemory    (outOfMemory)
  );

  arraySizeTable i_sizeTable (
    .clock       (clock),
    .reset       (reset),
    .array       (command.array),
    .index       (command.index),
    .updateArray (updateArray),
    .sizeOp      (sizeOp),
    .size        (size),
    .inBounds    (inBounds),
    .full        (full),
    .empty       (empty)
  );

  elementStore i_store (
    .clock       (clock),
    .array       (command.array),
    .index       (storeIndex),
    .writeEnable (storeWrite),
    .writeData   (updated),
    .readData    (stored)
  );

  elementAlu i_alu (
    .action  (command.action),
    .stored  (stored),
    .operand (command.data),
    .updated (updated)
  );

endmodule

//--- hdl/heapMemory_defs.svh
/*
  Sizing of the array heap. HEAP_ARRAYS must equal 2**HEAP_ARRAY_BITS and
  HEAP_LENGTH must equal 2**HEAP_INDEX_BITS. Data wider than 12 bits works
  as long as the testbench follows.
*/
`ifndef HEAP_MEMORY_DEFS_SVH
`define HEAP_MEMORY_DEFS_SVH

// ------------------------------
// Array numbering
// ------------------------------
`define HEAP_ARRAY_BITS 2                       // Bits in an array number
`define HEAP_ARRAYS     4                       // Arrays held in the heap

// ------------------------------
// Elements
// ------------------------------
`define HEAP_INDEX_BITS 2                       // Bits in an element index
`define HEAP_LENGTH     4                       // Max elements per array
`define HEAP_DATA_BITS  12                      // Width of one element

`endif

//--- hdl/heapPkg.sv
/*
  Types shared by the heap RTL and its testbench. Widths come from the
  sizing macros, so heapMemory_defs.svh must be on the include path.
*/
`include "heapMemory_defs.svh"

package heapPkg;

  // ------------------------------
  // Scalar types
  // ------------------------------
  typedef logic [`HEAP_ARRAY_BITS-1:0] arrayT;  // Array number
  typedef logic [`HEAP_INDEX_BITS-1:0] indexT;  // Element index
  typedef logic [`HEAP_INDEX_BITS:0]   sizeT;   // 0 up to HEAP_LENGTH inclusive
  typedef logic [`HEAP_DATA_BITS-1:0]  dataT;   // One element

  // ------------------------------
  // Opcodes and outcomes
  // ------------------------------
  typedef enum logic [4:0] {
    opNone,                                     // Idle cycle
    opWrite,                                    // Write element, grow size
    opRead,                                     // Read element
    opSize,                                     // Report size
    opPush,                                     // Append element
    opPop,                                      // Remove last element
    opAlloc,                                    // Hand out an array
    opFree,                                     // Return an array
    opAdd,                                      // Add, return new value
    opAddAfter,                                 // Add, return old value
    opSubtract,                                 // Subtract, return new value
    opSubAfter,                                 // Subtract, return old value
    opShiftLeft,
    opShiftRight,
    opNotLogical,                               // 1 if zero else 0
    opNot,                                      // Bitwise invert
    opOr,
    opXor,
    opAnd
  } opcodeT;

  typedef enum logic [2:0] {
    errNone,
    errNotAllocated,                            // Array number never handed out
    errFreed,                                   // Array returned to the stack
    errOutOfBounds,                             // Index at or past the size
    errFull,                                    // Push to a full array
    errEmpty,                                   // Pop from an empty array
    errOutOfMemory                              // No array left to allocate
  } errorT;

  typedef enum logic [2:0] {
    sizeKeep,
    sizeClear,                                  // New array starts empty
    sizeGrowTo,                                 // Write past the end
    sizeIncrement,                              // Push
    sizeDecrement                               // Pop
  } sizeOpT;

  // ------------------------------
  // Bus structs
  // ------------------------------
  typedef struct packed {
    opcodeT action;
    arrayT  array;
    indexT  index;
    dataT   data;
  } heapCommandT;                               // 21 bits

  typedef struct packed {
    dataT  data;
    errorT error;
  } heapResultT;                                // 15 bits

endpackage

//--- heapMemory.f
+incdir+hdl
hdl/heapPkg.sv
hdl/arrayAllocator.sv
hdl/arraySizeTable.sv
hdl/elementStore.sv
hdl/elementAlu.sv
hdl/heapMemory.sv
sim/clockGen.sv
sim/heapMemoryTb.sv

//--- sim/clockGen.sv
/*
  Testbench clock of period 40. Reset is high from time zero and drops
  on the third rising edge, so the DUT sees three reset cycles.
*/
module clockGen (
  output logic clock,
  output logic reset
);

  localparam int halfPeriod  = 20;              // Period 40
  localparam int resetCycles = 3;

  initial begin
    clock = 1'b0;
    forever begin
      #halfPeriod clock = ~clock;
    end
  end

  initial begin
    reset = 1'b1;
    repeat (resetCycles) @(posedge clock);
    reset <= 1'b0;                              // Released on an edge
  end

endmodule

//--- sim/heapMemoryTb.sv
/*
  Directed testbench for the array heap. Commands go out one at a time with
  an idle cycle after each; results are checked at the falling edge. The
  model below tracks sizes, allocation order and element contents.
*/
`include "heapMemory_defs.svh"

module heapMemoryTb;

  localparam int resultLatency = 1;             // Cycles from command to result
  localparam int resetLimit    = 20;            // Cycles allowed for reset release
  localparam int dataRange     = 1 << `HEAP_DATA_BITS;

  logic                 clock;
  logic                 reset;
  heapPkg::heapCommandT command;
  heapPkg::heapResultT  result;

  int          errorCount;
  int          checkCount;
  logic [15:0] lfsrState;                       // Galois LFSR state seeded with 9

  // ------------------------------
  // Reference model
  // ------------------------------
  heapPkg::dataT expectData;                    // Expected result.data
  int            modelSize [`HEAP_ARRAYS];
  int            modelMem  [`HEAP_ARRAYS][`HEAP_LENGTH];
  int            freedArrays [$];               // Newest freed at the back
  int            freshArray;                    // Next never-used array

  clockGen i_clockGen (
    .clock (clock),
    .reset (reset)
  );

  heapMemory i_dut (
    .clock   (clock),
    .reset   (reset),
    .command (command),
    .result  (result)
  );

  // One LFSR step per bit taken
  function automatic int randomBits(input int count);
    int value;
    int b;
    value = 0;
    for (b = 0; b < count; b++) begin
      value = (value << 1) | lfsrState[0];
      if (lfsrState[0]) begin
        lfsrState = (lfsrState >> 1) ^ 16'hB400; // Taps 16,14,13,11
      end else begin
        lfsrState = lfsrState >> 1;
      end
    end
    return value;
  endfunction

  function automatic heapPkg::heapCommandT makeCommand(input heapPkg::opcodeT action,
                                                       input int array, input int index,
                                                       input int data);
    heapPkg::heapCommandT cmd;
    cmd.action = action;
    cmd.array  = heapPkg::arrayT'(array);
    cmd.index  = heapPkg::indexT'(index);
    cmd.data   = heapPkg::dataT'(data);
    return cmd;
  endfunction

  // New element value by the operation rules
  function automatic int expectedElement(input heapPkg::opcodeT action,
                                         input int stored, input int operand);
    int value;
    case (action)
      heapPkg::opAdd,
      heapPkg::opAddAfter:   value = (stored + operand) % dataRange;
      heapPkg::opSubtract,
      heapPkg::opSubAfter:   value = (stored - operand + dataRange) % dataRange;
      heapPkg::opShiftLeft:  value = (operand >= `HEAP_DATA_BITS) ? 0
                                     : (stored * (1 << operand)) % dataRange;
      heapPkg::opShiftRight: value = (operand >= `HEAP_DATA_BITS) ? 0
                                     : stored / (1 << operand);
      heapPkg::opNotLogical: value = (stored == 0) ? 1 : 0;
      heapPkg::opNot:        value = dataRange - 1 - stored;
      heapPkg::opOr:         value = stored | operand;
      heapPkg::opXor:        value = stored ^ operand;
      heapPkg::opAnd:        value = stored & operand;
      default:               value = stored;
    endcase
    return value;
  endfunction

  // Applies a successful command to the model
  function automatic void updateModel(input heapPkg::heapCommandT cmd);
    int a;
    int i;
    int old;
    a = int'(cmd.array);
    i = int'(cmd.index);
    case (cmd.action)
      heapPkg::opAlloc: begin
        if (freedArrays.size() > 0) begin
          a = freedArrays.pop_back();           // Reuse newest freed
        end else begin
          a = freshArray;
          freshArray++;
        end
        modelSize[a] = 0;
        expectData   = heapPkg::dataT'(a);
      end
      heapPkg::opFree: freedArrays.push_back(a);
      heapPkg::opWrite: begin
        modelMem[a][i] = int'(cmd.data);
        if (i >= modelSize[a]) begin
          modelSize[a] = i + 1;                 // Grows to cover the index
        end
        expectData = cmd.data;
      end
      heapPkg::opRead: expectData = heapPkg::dataT'(modelMem[a][i]);
      heapPkg::opSize: expectData = heapPkg::dataT'(modelSize[a]);
      heapPkg::opPush: begin
        modelMem[a][modelSize[a]] = int'(cmd.data);
        modelSize[a]++;                         // Data holds
      end
      heapPkg::opPop: begin
        modelSize[a]--;
        expectData = heapPkg::dataT'(modelMem[a][modelSize[a]]);
      end
      heapPkg::opNone: begin
      end
      default: begin                            // Element operations
        old            = modelMem[a][i];
        modelMem[a][i] = expectedElement(cmd.action, old, int'(cmd.data));
        if (cmd.action == heapPkg::opAddAfter || cmd.action == heapPkg::opSubAfter) begin
          expectData = heapPkg::dataT'(old);
        end else begin
          expectData = heapPkg::dataT'(modelMem[a][i]);
        end
      end
    endcase
  endfunction

  // ------------------------------
  // Drive and check
  // ------------------------------
  task automatic issue(input heapPkg::heapCommandT next);
    int edges;
    @(posedge clock);
    command <= next;                            // Sampled on the next edge
    for (edges = 0; edges < resultLatency; edges++) begin
      @(posedge clock);
    end
    command <= makeCommand(heapPkg::opNone, 0, 0, 0);
    @(negedge clock);                           // Result settled
  endtask

  task automatic checkResult(input string what, input heapPkg::errorT expError);
    checkCount++;
    assert (result.error === expError) else begin
      errorCount++;
      $display("MISMATCH result.error (%s): got 0x%0h, expected 0x%0h",
               what, result.error, expError);
    end
    checkCount++;
    assert (result.data === expectData) else begin
      errorCount++;
      $display("MISMATCH result.data (%s): got 0x%0h, expected 0x%0h",
               what, result.data, expectData);
    end
  endtask

  task automatic runCommand(input string what, input heapPkg::opcodeT action,
                            input int array, input int index, input int data,
                            input heapPkg::errorT expError);
    heapPkg::heapCommandT cmd;
    cmd = makeCommand(action, array, index, data);
    if (expError == heapPkg::errNone) begin
      updateModel(cmd);                         // Failed commands change nothing
    end
    issue(cmd);
    checkResult(what, expError);
  endtask

  // ------------------------------
  // Directed tests
  // ------------------------------
  task automatic accessUnallocated();
    runCommand("write before any alloc", heapPkg::opWrite, 1, 0, 12'h123,
               heapPkg::errNotAllocated);
    runCommand("read before any alloc", heapPkg::opRead, 0, 0, 0, heapPkg::errNotAllocated);
    runCommand("free before any alloc", heapPkg::opFree, 2, 0, 0, heapPkg::errNotAllocated);
  endtask

  task automatic allocateUntilFull();
    int n;
    for (n = 0; n < `HEAP_ARRAYS; n++) begin
      runCommand($sformatf("alloc %0d", n), heapPkg::opAlloc, 0, 0, 0, heapPkg::errNone);
    end
    runCommand("alloc past capacity", heapPkg::opAlloc, 0, 0, 0, heapPkg::errOutOfMemory);
  endtask

  task automatic writeReadSize();
    runCommand("write array 0 index 2", heapPkg::opWrite, 0, 2, randomBits(12),
               heapPkg::errNone);
    runCommand("size after write", heapPkg::opSize, 0, 0, 0, heapPkg::errNone);
    runCommand("read array 0 index 2", heapPkg::opRead, 0, 2, 0, heapPkg::errNone);
    runCommand("read past size", heapPkg::opRead, 0, 3, 0, heapPkg::errOutOfBounds);
  endtask

  task automatic pushThenPop();
    int n;
    for (n = 0; n < `HEAP_LENGTH; n++) begin
      runCommand($sformatf("push %0d", n), heapPkg::opPush, 1, 0, randomBits(12),
                 heapPkg::errNone);
    end
    runCommand("push to full array", heapPkg::opPush, 1, 0, randomBits(12), heapPkg::errFull);
    for (n = 0; n < `HEAP_LENGTH; n++) begin
      runCommand($sformatf("pop %0d", n), heapPkg::opPop, 1, 0, 0, heapPkg::errNone);
    end
    runCommand("pop from empty array", heapPkg::opPop, 1, 0, 0, heapPkg::errEmpty);
  endtask

  task automatic elementOperations();
    int              code;
    int              operand;
    heapPkg::opcodeT action;
    for (code = int'(heapPkg::opAdd); code <= int'(heapPkg::opAnd); code++) begin
      action = heapPkg::opcodeT'(code);
      if (action == heapPkg::opShiftLeft || action == heapPkg::opShiftRight) begin
        operand = randomBits(4);                // Reaches the 12-and-up case
      end else begin
        operand = randomBits(12);
      end
      runCommand("load known element", heapPkg::opWrite, 2, 1, randomBits(12),
                 heapPkg::errNone);
      runCommand(action.name(), action, 2, 1, operand, heapPkg::errNone);
      runCommand({action.name(), " read back"}, heapPkg::opRead, 2, 1, 0, heapPkg::errNone);
    end
    // Zero element for the logical not
    runCommand("load zero", heapPkg::opWrite, 2, 1, 0, heapPkg::errNone);
    runCommand("logical not of zero", heapPkg::opNotLogical, 2, 1, 0, heapPkg::errNone);
    runCommand("add past size", heapPkg::opAdd, 2, 3, 1, heapPkg::errOutOfBounds);
  endtask

  task automatic freeAndReuse();
    runCommand("fill array 3", heapPkg::opWrite, 3, 1, randomBits(12), heapPkg::errNone);
    runCommand("free array 2", heapPkg::opFree, 2, 0, 0, heapPkg::errNone);
    runCommand("free array 3", heapPkg::opFree, 3, 0, 0, heapPkg::errNone);
    runCommand("write to freed array", heapPkg::opWrite, 3, 0, randomBits(12),
               heapPkg::errFreed);
    runCommand("second free", heapPkg::opFree, 3, 0, 0, heapPkg::errFreed);
    // Idle right after a refused command must clear the error
    runCommand("idle cycle", heapPkg::opNone, 0, 0, 0, heapPkg::errNone);
    runCommand("alloc reuses newest", heapPkg::opAlloc, 0, 0, 0, heapPkg::errNone);
    runCommand("size of reused array", heapPkg::opSize, 3, 0, 0, heapPkg::errNone);
  endtask

  // ------------------------------
  // Sequence
  // ------------------------------
  initial begin
    int waited;
    errorCount = 0;
    checkCount = 0;
    lfsrState  = 16'd9;
    expectData = '0;                            // Reset value of result.data
    freshArray = 0;
    for (waited = 0; waited < `HEAP_ARRAYS; waited++) begin
      modelSize[waited] = 0;
    end
    command = makeCommand(heapPkg::opNone, 0, 0, 0);
    waited  = 0;
    do begin
      @(negedge clock);
      waited++;
    end while (reset !== 1'b0 && waited < resetLimit);
    if (reset !== 1'b0) begin
      $display("Reset still asserted after %0d cycles", waited);
      $display("Simulation failed");
    end else begin
      accessUnallocated();
      allocateUntilFull();
      writeReadSize();
      pushThenPop();
      elementOperations();
      freeAndReuse();
      $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
      if (errorCount == 0) begin
        $display("Simulation completed successfully");
      end else begin
        $display("Simulation failed");
      end
    end
    $finish;
  end

endmodule
